//--- Makefile
BUILD := obj_dir
LOG   := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module tb_fetch_cache -Mdir $(BUILD)

run: compile
	./$(BUILD)/Vtb_fetch_cache > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- common/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

  ////////////////////////////////////////
  // memory bus
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_command_t;

  // cache toward memory
  typedef struct packed {
    bus_command_t command;
    logic [63:0]  addr;
  } mem_request_t;

  // memory toward cache
  typedef struct packed {
    // accept tag for this cycle's request, zero if refused
    logic [`MEM_TAG_BITS-1:0] response;
    logic [63:0]              data;
    // tag of the returning data, zero when idle
    logic [`MEM_TAG_BITS-1:0] tag;
  } mem_response_t;

  ////////////////////////////////////////
  // prefetch queue
  ////////////////////////////////////////

  typedef struct packed {
    // line aligned
    logic [63:0]              address;
    // zero until memory accepts the load
    logic [`MEM_TAG_BITS-1:0] mem_tag;
    logic                     valid;
  } icache_buffer_t;

  localparam icache_buffer_t empty_icache_entry = '{
    address: 64'h0,
    mem_tag: '0,
    valid:   1'b0
  };

endpackage

//--- common/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

////////////////////////////////////////
// cache geometry
////////////////////////////////////////

// 32 lines of 8 bytes, direct mapped
`define NUM_SET_BITS 5

// tag bits above the set index, within addr[31:3]
`define NUM_TAG_BITS 24

////////////////////////////////////////
// miss handling
////////////////////////////////////////

// prefetch queue depth
`define INST_BUFFER_LEN 4

// memory transaction tag, zero means none
`define MEM_TAG_BITS 4

`endif

//--- icache/addr_cam.sv
`timescale 1ns/1ps

module addr_cam #(
  parameter int LENGTH = 4
) (
  input  icache_pkg::icache_buffer_t [LENGTH-1:0] entries,
  input  logic [63:0]                              search_a,
  input  logic [63:0]                              search_b,
  output logic [LENGTH-1:0]                        hit_a,
  output logic [LENGTH-1:0]                        hit_b
);

  logic [63:0] line_a;
  logic [63:0] line_b;

  // compare on line granularity
  assign line_a = {search_a[63:3], 3'b000};
  assign line_b = {search_b[63:3], 3'b000};

  always_comb begin
    for (int i = 0; i < LENGTH; i++) begin
      // empty slots never match
      hit_a[i] = entries[i].valid && (entries[i].address == line_a);
      hit_b[i] = entries[i].valid && (entries[i].address == line_b);
    end
  end

endmodule

//--- icache/cachemem.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module cachemem (
  input  logic                     clock,
  input  logic                     reset,

  // port 0, fetch address
  input  logic [`NUM_SET_BITS-1:0] rd_idx0,
  input  logic [`NUM_TAG_BITS-1:0] rd_tag0,

  // port 1, next line lookup
  input  logic [`NUM_SET_BITS-1:0] rd_idx1,
  input  logic [`NUM_TAG_BITS-1:0] rd_tag1,

  // fill
  input  logic                     wr_en,
  input  logic [`NUM_SET_BITS-1:0] wr_idx,
  input  logic [`NUM_TAG_BITS-1:0] wr_tag,
  input  logic [63:0]              wr_data,

  output logic [63:0]              rd_data0,
  output logic                     rd_valid0,
  output logic                     rd_valid1
);

  localparam int NUM_LINES = 1 << `NUM_SET_BITS;

  logic [63:0]              data_mem [NUM_LINES];
  logic [`NUM_TAG_BITS-1:0] tag_mem  [NUM_LINES];
  logic [NUM_LINES-1:0]     line_valid;

  logic tag_match0;
  logic tag_match1;

  ////////////////////////////////////////
  // read ports
  ////////////////////////////////////////

  assign tag_match0 = (tag_mem[rd_idx0] == rd_tag0);
  assign tag_match1 = (tag_mem[rd_idx1] == rd_tag1);

  assign rd_data0  = data_mem[rd_idx0];
  assign rd_valid0 = line_valid[rd_idx0] && tag_match0;

  // only presence matters on the next line
  assign rd_valid1 = line_valid[rd_idx1] && tag_match1;

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

  // lines stay valid once filled, code is never written
  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else if (wr_en) begin
      line_valid[wr_idx] <= 1'b1;
    end
  end

endmodule

//--- icache/icache.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache (
  input  logic                      clock,
  input  logic                      reset,

  // from fetch
  input  logic [63:0]               fetch_addr,

  // from memory
  input  icache_pkg::mem_response_t mem_resp,

  // to fetch
  output logic [63:0]               fetch_data,
  output logic                      fetch_valid,

  // to memory
  output icache_pkg::mem_request_t  mem_req
);

  import icache_pkg::*;

  localparam int QLEN     = `INST_BUFFER_LEN;
  localparam int PTR_BITS = $clog2(QLEN + 1);

  localparam logic [PTR_BITS-1:0] PTR_ONE  = PTR_BITS'(1);
  localparam logic [PTR_BITS-1:0] PTR_FULL = PTR_BITS'(QLEN);

  typedef enum logic {
    ISSUE_IDLE,
    ISSUE_SEND
  } issue_state_t;

  // fetch side addresses
  logic [63:0]              line_addr;
  logic [63:0]              next_line_addr;
  logic [`NUM_SET_BITS-1:0] fetch_idx;
  logic [`NUM_TAG_BITS-1:0] fetch_tag;
  logic [`NUM_SET_BITS-1:0] next_idx;
  logic [`NUM_TAG_BITS-1:0] next_tag;
  logic                     fetch_hit;
  logic                     next_hit;

  // fill side
  logic                     fill_en;
  logic [`NUM_SET_BITS-1:0] fill_idx;
  logic [`NUM_TAG_BITS-1:0] fill_tag;

  // prefetch queue
  icache_buffer_t [QLEN-1:0] queue;
  icache_buffer_t [QLEN-1:0] queue_next;
  logic [PTR_BITS-1:0]       tail;
  logic [PTR_BITS-1:0]       tail_next;
  logic [PTR_BITS-1:0]       issue_ptr;
  logic [PTR_BITS-1:0]       issue_ptr_next;
  issue_state_t              issue_state;
  issue_state_t              issue_state_next;

  logic [QLEN-1:0] queued_line;
  logic [QLEN-1:0] queued_next;
  logic            want_line;
  logic            want_next;
  logic            accepted;

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////

  assign line_addr      = {fetch_addr[63:3], 3'b000};
  assign next_line_addr = line_addr + 64'd8;

  assign {fetch_tag, fetch_idx} = line_addr[31:3];
  assign {next_tag, next_idx}   = next_line_addr[31:3];

  // head entry is always the oldest accepted load
  assign {fill_tag, fill_idx} = queue[0].address[31:3];
  assign fill_en = queue[0].valid && (queue[0].mem_tag != '0) &&
                   (mem_resp.tag == queue[0].mem_tag);

  cachemem lines (
    .clock     (clock),
    .reset     (reset),
    .rd_idx0   (fetch_idx),
    .rd_tag0   (fetch_tag),
    .rd_idx1   (next_idx),
    .rd_tag1   (next_tag),
    .wr_en     (fill_en),
    .wr_idx    (fill_idx),
    .wr_tag    (fill_tag),
    .wr_data   (mem_resp.data),
    .rd_data0  (fetch_data),
    .rd_valid0 (fetch_hit),
    .rd_valid1 (next_hit)
  );

  assign fetch_valid = fetch_hit;

  addr_cam #(
    .LENGTH (QLEN)
  ) pending (
    .entries  (queue),
    .search_a (line_addr),
    .search_b (next_line_addr),
    .hit_a    (queued_line),
    .hit_b    (queued_next)
  );

  // prefetch the successor only on a fetch miss
  assign want_line = !fetch_hit && (queued_line == '0);
  assign want_next = !fetch_hit && !next_hit && (queued_next == '0);

  ////////////////////////////////////////
  // memory command
  ////////////////////////////////////////

  assign accepted = (issue_state == ISSUE_SEND) && (mem_resp.response != '0);

  always_comb begin
    mem_req.command = BUS_NONE;
    mem_req.addr    = 64'h0;
    if (issue_state == ISSUE_SEND) begin
      mem_req.command = BUS_LOAD;
      mem_req.addr    = queue[issue_ptr].address;
    end
  end

  ////////////////////////////////////////
  // queue update
  ////////////////////////////////////////

  always_comb begin
    queue_next     = queue;
    tail_next      = tail;
    issue_ptr_next = issue_ptr;

    // memory took the load, keep its tag
    if (accepted) begin
      queue_next[issue_ptr].mem_tag = mem_resp.response;
      issue_ptr_next = issue_ptr + PTR_ONE;
    end

    // head retires on its data
    if (fill_en) begin
      queue_next     = {empty_icache_entry, queue_next[QLEN-1:1]};
      tail_next      = tail_next - PTR_ONE;
      issue_ptr_next = issue_ptr_next - PTR_ONE;
    end

    // missing line first, then its successor if room remains
    if (want_line && (tail_next < PTR_FULL)) begin
      queue_next[tail_next] = '{address: line_addr, mem_tag: '0, valid: 1'b1};
      tail_next = tail_next + PTR_ONE;
    end
    if (want_next && (tail_next < PTR_FULL)) begin
      queue_next[tail_next] = '{address: next_line_addr, mem_tag: '0, valid: 1'b1};
      tail_next = tail_next + PTR_ONE;
    end

    if (issue_ptr_next < tail_next) begin
      issue_state_next = ISSUE_SEND;
    end else begin
      issue_state_next = ISSUE_IDLE;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      queue       <= {QLEN{empty_icache_entry}};
      tail        <= '0;
      issue_ptr   <= '0;
      issue_state <= ISSUE_IDLE;
    end else begin
      queue       <= queue_next;
      tail        <= tail_next;
      issue_ptr   <= issue_ptr_next;
      issue_state <= issue_state_next;
    end
  end

endmodule

//--- tb.f
+incdir+common
common/icache_pkg.sv
icache/cachemem.sv
icache/addr_cam.sv
icache/icache.sv
verilog/fetch_cache_top.sv
tb/tb_fetch_cache.sv

//--- tb/tb_fetch_cache.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module tb_fetch_cache;

  import icache_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_STEPS  = 400;
  localparam int STEP_BOUND = 20;
  localparam int NUM_LINES  = 1 << `NUM_SET_BITS;

  // fetch region is 1 KB, aligned
  localparam logic [63:0] REGION_BASE = 64'h0000_0000_0040_0000;
  localparam logic [`MEM_TAG_BITS-1:0] TAG_ONE = {{(`MEM_TAG_BITS-1){1'b0}}, 1'b1};

  typedef struct packed {
    logic [63:0]              addr;
    logic [`MEM_TAG_BITS-1:0] tag;
    int                       due;
  } pending_load_t;

  logic          clock;
  logic          reset;
  logic [63:0]   fetch_addr;
  mem_response_t mem_resp;
  logic [63:0]   fetch_data;
  logic          fetch_valid;
  mem_request_t  mem_req;

  // reference model state
  logic [31:0]              lfsr_state;
  logic [63:0]              model_line [NUM_LINES];
  logic [NUM_LINES-1:0]     model_valid;
  pending_load_t            pending [$];
  logic [`MEM_TAG_BITS-1:0] next_tag;

  logic        fill_now;
  logic [63:0] fill_line;
  logic        refused;
  logic [63:0] refused_addr;
  logic        expect_active;
  logic [63:0] expect_line;
  int          expect_deadline;
  logic        advance;
  logic        fresh;

  int cycle;
  int steps_done;
  int held_cycles;
  int fill_count;
  int mismatch_count;
  int error_count;

  fetch_cache_top dut (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .mem_resp    (mem_resp),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .mem_req     (mem_req)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    // taps 32, 22, 2, 1
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  function automatic logic [7:0] random_bits(input int count);
    logic [7:0] value;
    value = 8'd0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[6:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic logic [63:0] line_of(input logic [63:0] addr);
    return {addr[63:3], 3'b000};
  endfunction

  // addr[31:3] in the low word, inverted copy above
  function automatic logic [63:0] memory_word(input logic [63:0] line);
    logic [31:0] low;
    low = {3'b000, line[31:3]};
    return {~low, low};
  endfunction

  function automatic logic model_hit(input logic [63:0] line);
    logic [`NUM_SET_BITS-1:0] idx;
    idx = line[3 +: `NUM_SET_BITS];
    return model_valid[idx] && (model_line[idx] == line);
  endfunction

  function automatic logic is_pending(input logic [63:0] line);
    logic found;
    found = 1'b0;
    foreach (pending[i]) begin
      if (pending[i].addr == line) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  task automatic serve_memory();
    pending_load_t load;
    logic [7:0]    delay;
    mem_resp = '0;
    // oldest accepted load returns once its latency is over
    if (pending.size() > 0 && pending[0].due <= cycle) begin
      load          = pending.pop_front();
      mem_resp.tag  = load.tag;
      mem_resp.data = memory_word(load.addr);
      fill_now      = 1'b1;
      fill_line     = load.addr;
    end
    if (refused) begin
      assert (mem_req.command == BUS_LOAD && mem_req.addr == refused_addr) else begin
        error_count++;
        $display("refused load for %h was not repeated in the next cycle", refused_addr);
      end
    end
    refused = 1'b0;
    if (mem_req.command == BUS_LOAD) begin
      if (expect_active && mem_req.addr == expect_line) begin
        expect_active = 1'b0;
      end
      assert (!model_hit(mem_req.addr)) else begin
        error_count++;
        $display("load issued for line %h which is already cached", mem_req.addr);
      end
      assert (!is_pending(mem_req.addr)) else begin
        error_count++;
        $display("load issued for line %h while an earlier one is outstanding", mem_req.addr);
      end
      // refuse about one load in eight
      if (random_bits(3) != 8'd0) begin
        delay = random_bits(2);
        mem_resp.response = next_tag;
        load = '{addr: mem_req.addr, tag: next_tag, due: cycle + 3 + int'(delay)};
        pending.push_back(load);
        next_tag = (next_tag == '1) ? TAG_ONE : next_tag + TAG_ONE;
        assert (pending.size() <= `INST_BUFFER_LEN) else begin
          error_count++;
          $display("more than %0d loads outstanding at once", `INST_BUFFER_LEN);
        end
      end else begin
        refused      = 1'b1;
        refused_addr = mem_req.addr;
      end
    end
  endtask

  ////////////////////////////////////////
  // fetch stimulus and checks
  ////////////////////////////////////////

  task automatic drive_fetch();
    logic [7:0] jump;
    logic [9:0] offset;
    if (advance) begin
      offset = fetch_addr[9:0] + 10'd8;
      if (random_bits(3) == 8'd0) begin
        jump   = random_bits(7);
        offset = {jump[6:0], 3'b000};
      end
      fetch_addr  = REGION_BASE | {54'h0, offset};
      advance     = 1'b0;
      fresh       = 1'b1;
      held_cycles = 0;
    end
  endtask

  task automatic check_outputs();
    logic [63:0]              line;
    logic                     expected_valid;
    logic [`NUM_SET_BITS-1:0] idx;
    line = line_of(fetch_addr);
    expected_valid = model_hit(line);
    if (cycle == 0) begin
      assert (mem_req.command == BUS_NONE) else begin
        error_count++;
        $display("memory command is not idle right after reset");
      end
    end
    assert (fetch_valid == expected_valid) else begin
      mismatch_count++;
      $display("Mismatch fetch_valid at %h: expected %b, actual %b",
               fetch_addr, expected_valid, fetch_valid);
    end
    if (fetch_valid) begin
      assert (fetch_data == memory_word(line)) else begin
        mismatch_count++;
        $display("Mismatch fetch_data at %h: expected %h, actual %h",
                 fetch_addr, memory_word(line), fetch_data);
      end
    end
    // a fresh miss should pull in the next line too
    if (fresh && !fetch_valid && !expect_active &&
        !model_hit(line + 64'd8) && !is_pending(line + 64'd8)) begin
      expect_active   = 1'b1;
      expect_line     = line + 64'd8;
      expect_deadline = cycle + 2 * STEP_BOUND;
    end
    fresh = 1'b0;
    assert (!expect_active || cycle <= expect_deadline) else begin
      error_count++;
      $display("next line %h was never requested after a miss", expect_line);
      expect_active = 1'b0;
    end
    if (fetch_valid) begin
      steps_done++;
      advance = 1'b1;
    end else begin
      held_cycles++;
      assert (held_cycles != STEP_BOUND + 1) else begin
        error_count++;
        $display("fetch address %h not served within %0d cycles", fetch_addr, STEP_BOUND);
      end
    end
    // the DUT writes this fill at the coming edge
    if (fill_now) begin
      idx = fill_line[3 +: `NUM_SET_BITS];
      model_line[idx]  = fill_line;
      model_valid[idx] = 1'b1;
      fill_now = 1'b0;
      fill_count++;
    end
  endtask

  ////////////////////////////////////////
  // clock, main sequence, watchdog
  ////////////////////////////////////////

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    reset      = 1'b1;
    fetch_addr = REGION_BASE;
    mem_resp   = '0;
    lfsr_state = 32'h6b53_6042;
    model_valid = '0;
    for (int i = 0; i < NUM_LINES; i++) begin
      model_line[i] = 64'h0;
    end
    next_tag       = TAG_ONE;
    fill_now       = 1'b0;
    fill_line      = 64'h0;
    refused        = 1'b0;
    refused_addr   = 64'h0;
    expect_active  = 1'b0;
    expect_line    = 64'h0;
    advance        = 1'b0;
    fresh          = 1'b1;
    cycle          = 0;
    steps_done     = 0;
    held_cycles    = 0;
    fill_count     = 0;
    mismatch_count = 0;
    error_count    = 0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    while (steps_done < NUM_STEPS) begin
      serve_memory();
      drive_fetch();
      // outputs settle well before the rising edge
      #(CLK_PERIOD / 4);
      check_outputs();
      @(negedge clock);
      cycle++;
    end
    $display("%0d mismatches, %0d other errors, %0d fetch steps, %0d fills",
             mismatch_count, error_count, steps_done, fill_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (NUM_STEPS * STEP_BOUND + 8));
    $display("watchdog expired with %0d of %0d fetch steps done", steps_done, NUM_STEPS);
    $display("%0d mismatches, %0d other errors, %0d fetch steps, %0d fills",
             mismatch_count, error_count, steps_done, fill_count);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- verilog/fetch_cache_top.sv
`timescale 1ns/1ps

module fetch_cache_top (
  input  logic                      clock,
  input  logic                      reset,

  // fetch stage
  input  logic [63:0]               fetch_addr,
  output logic [63:0]               fetch_data,
  output logic                      fetch_valid,

  // main memory, tagged and pipelined
  input  icache_pkg::mem_response_t mem_resp,
  output icache_pkg::mem_request_t  mem_req
);

  ////////////////////////////////////////
  // instruction cache
  ////////////////////////////////////////

  // hits answer combinationally, misses go through the prefetch queue
  icache cache (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .mem_resp    (mem_resp),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .mem_req     (mem_req)
  );

endmodule
